// ==== hdl/dfe_pkg.sv ====
package dfe_pkg;

    localparam int SIG_W     = 8;   // input sample width, signed.
    localparam int TAP_COUNT = 5;   // tap 0 is the main cursor.
    localparam int LOC_W     = 3;   // tap address width.
    localparam int TAP_W     = 16;  // expanded tap width, signed.
    localparam int ACC_W     = 20;  // isi sum and equalized value width.

    // tap as mantissa times two to the power of shift.
    typedef struct packed {
        logic signed [SIG_W-1:0] mant;
        logic        [2:0]       shift;
    } coef_t;

    typedef enum logic [1:0] {
        sym_m3 = 2'b00,
        sym_m1 = 2'b01,
        sym_p1 = 2'b10,
        sym_p3 = 2'b11
    } pam4_sym_t;

    typedef enum logic {
        st_fill,
        st_run
    } dfe_state_t;

    typedef struct packed {
        logic signed [ACC_W-1:0] equalized;
        pam4_sym_t               symbol;
        logic                    valid;
    } dfe_out_t;

    // signed pam4 level of a decided symbol.
    function automatic logic signed [2:0] sym_level(input pam4_sym_t sym);
        logic signed [2:0] lvl;
        case (sym)
            sym_m3:  lvl = -3'sd3;
            sym_m1:  lvl = -3'sd1;
            sym_p1:  lvl = 3'sd1;
            default: lvl = 3'sd3;
        endcase
        return lvl;
    endfunction

endpackage

// ==== hdl/dfe_ctrl.sv ====
`timescale 1ns/1ps

module dfe_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic all_filled,
    input  logic sample_valid,
    input  logic load_mem,
    output logic accept,
    output logic ready
);

    import dfe_pkg::*;

    dfe_state_t state;
    dfe_state_t state_nxt;

    // only leaves st_fill once, reset is the only way back.
    always_comb begin
        state_nxt = state;
        case (state)
            st_fill: begin
                if (all_filled) begin
                    state_nxt = st_run;
                end
            end
            st_run: begin
                state_nxt = st_run; // taps rewritten in place.
            end
            default: begin
                state_nxt = st_fill;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_fill;
        end else begin
            state <= state_nxt;
        end
    end

    assign ready = (state == st_run);

    // sample coinciding with a tap write is dropped.
    assign accept = sample_valid && (state == st_run) && !load_mem;

endmodule

// ==== hdl/coef_fill_tracker.sv ====
`timescale 1ns/1ps

module coef_fill_tracker (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      load_mem,
    input  logic [dfe_pkg::LOC_W-1:0] location,
    output logic                      wr_en,
    output logic                      all_filled
);

    import dfe_pkg::*;

    logic [TAP_COUNT-1:0] written;   // one bit per tap seen.
    logic [LOC_W-1:0]     fill_cnt;  // number of distinct taps written.
    logic [LOC_W-1:0]     cnt_nxt;
    logic                 new_loc;

    assign wr_en   = load_mem && (location < LOC_W'(TAP_COUNT)); // out of range ignored.
    assign new_loc = wr_en && !written[location];                // rewrites do not count.
    assign cnt_nxt = fill_cnt + LOC_W'(new_loc);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            written    <= '0;
            fill_cnt   <= '0;
            all_filled <= 1'b0;
        end else begin
            if (new_loc) begin
                written[location] <= 1'b1;
                fill_cnt          <= cnt_nxt;
            end
            // sticky, set on the same edge as the last new tap.
            if (cnt_nxt == LOC_W'(TAP_COUNT)) begin
                all_filled <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/coef_bank.sv ====
`timescale 1ns/1ps

module coef_bank (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             wr_en,
    input  logic        [dfe_pkg::LOC_W-1:0] location,
    input  dfe_pkg::coef_t                   mem_data,
    output logic signed [dfe_pkg::TAP_W-1:0] taps [dfe_pkg::TAP_COUNT]
);

    import dfe_pkg::*;

    coef_t coefs [TAP_COUNT];  // stored mantissa and shift per tap.

    // wr_en is already range checked by the tracker.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int k = 0; k < TAP_COUNT; k++) begin
                coefs[k] <= '0;
            end
        end else if (wr_en) begin
            coefs[location] <= mem_data;
        end
    end

    // h = mant * 2^shift, done as sign extension then arithmetic shift.
    always_comb begin
        logic signed [TAP_W-1:0] mant_ext;
        for (int k = 0; k < TAP_COUNT; k++) begin
            mant_ext = TAP_W'($signed(coefs[k].mant));
            taps[k]  = mant_ext <<< coefs[k].shift;
        end
    end

endmodule

// ==== hdl/symbol_slicer.sv ====
`timescale 1ns/1ps

module symbol_slicer (
    input  logic signed [dfe_pkg::ACC_W-1:0] equalized,
    input  logic signed [dfe_pkg::TAP_W-1:0] main_tap,
    output dfe_pkg::pam4_sym_t               symbol
);

    import dfe_pkg::*;

    logic signed [ACC_W-1:0] thr_hi;  // +2*h0.
    logic signed [ACC_W-1:0] thr_lo;  // -2*h0.

    // thresholds scale with the main cursor instead of dividing by it.
    assign thr_hi = ACC_W'(main_tap) <<< 1;
    assign thr_lo = -thr_hi;

    always_comb begin
        if (equalized >= thr_hi) begin
            symbol = sym_p3;
        end else if (equalized >= 0) begin
            symbol = sym_p1;
        end else if (equalized >= thr_lo) begin
            symbol = sym_m1;
        end else begin
            symbol = sym_m3;
        end
    end

endmodule

// ==== hdl/isi_canceller.sv ====
`timescale 1ns/1ps

module isi_canceller (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             accept,
    input  logic signed [dfe_pkg::SIG_W-1:0] sample,
    input  logic signed [dfe_pkg::TAP_W-1:0] taps [dfe_pkg::TAP_COUNT],
    output dfe_pkg::dfe_out_t                result
);

    import dfe_pkg::*;

    localparam int HIST_LEN = TAP_COUNT - 1;  // one slot per post-cursor.

    pam4_sym_t               hist [HIST_LEN];  // hist[0] is d[n-1].
    logic signed [ACC_W-1:0] isi_sum;
    logic signed [ACC_W-1:0] eq_val;
    pam4_sym_t               sym_now;
    logic signed [ACC_W-1:0] eq_q;
    pam4_sym_t               sym_q;
    logic                    valid_q;

    // predicted isi from the last four decisions.
    always_comb begin
        isi_sum = '0;
        for (int k = 1; k < TAP_COUNT; k++) begin
            isi_sum = isi_sum + ACC_W'(taps[k]) * ACC_W'(sym_level(hist[k-1]));
        end
    end

    assign eq_val = ACC_W'(sample) - isi_sum;

    symbol_slicer u_slicer (
        .equalized (eq_val),
        .main_tap  (taps[0]),
        .symbol    (sym_now)
    );

    // decision history, starts at +1 everywhere.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int k = 0; k < HIST_LEN; k++) begin
                hist[k] <= sym_p1;
            end
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;  // result lives for one cycle.
            if (accept) begin
                hist[0] <= sym_now;
                for (int k = 1; k < HIST_LEN; k++) begin
                    hist[k] <= hist[k-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            eq_q  <= eq_val;
            sym_q <= sym_now;
        end
    end

    assign result.equalized = eq_q;
    assign result.symbol    = sym_q;
    assign result.valid     = valid_q;

endmodule

// ==== hdl/dfe_top.sv ====
`timescale 1ns/1ps

module dfe_top (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic signed [dfe_pkg::SIG_W-1:0] sample,
    input  logic                             sample_valid,
    input  logic                             load_mem,
    input  logic        [dfe_pkg::LOC_W-1:0] location,
    input  dfe_pkg::coef_t                   mem_data,
    output logic                             done_wait,
    output dfe_pkg::dfe_out_t                result
);

    import dfe_pkg::*;

    logic                    all_filled;
    logic                    wr_en;
    logic                    accept;
    logic                    ready;
    logic signed [TAP_W-1:0] taps [TAP_COUNT];

    // fill then run sequencing and sample qualification.
    dfe_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .all_filled   (all_filled),
        .sample_valid (sample_valid),
        .load_mem     (load_mem),
        .accept       (accept),
        .ready        (ready)
    );

    // range check and tracking of written taps.
    coef_fill_tracker u_fill (
        .clk        (clk),
        .rstn       (rstn),
        .load_mem   (load_mem),
        .location   (location),
        .wr_en      (wr_en),
        .all_filled (all_filled)
    );

    coef_bank u_bank (
        .clk      (clk),
        .rstn     (rstn),
        .wr_en    (wr_en),
        .location (location),
        .mem_data (mem_data),
        .taps     (taps)
    );

    // equalize, slice and register one sample per accept.
    isi_canceller u_canceller (
        .clk    (clk),
        .rstn   (rstn),
        .accept (accept),
        .sample (sample),
        .taps   (taps),
        .result (result)
    );

    assign done_wait = ready;

endmodule

// ==== verification/dfe_tb.sv ====
`timescale 1ns/1ps

module dfe_tb;

    import dfe_pkg::*;

    localparam int ROWS        = 14;
    localparam int RAND_COUNT  = 200;
    localparam int BURST_COUNT = 8;
    localparam int READY_EDGES = 2;     // edges from last tap write to done_wait.
    localparam int RUN_LIMIT   = 2000;  // cycles before the watchdog fires.

    typedef struct packed {
        int        smp;
        logic      vld;
        pam4_sym_t sym;
        int        eq;
    } row_t;

    logic                    clk;
    logic                    rstn;
    logic signed [SIG_W-1:0] sample;
    logic                    sample_valid;
    logic                    load_mem;
    logic        [LOC_W-1:0] location;
    coef_t                   mem_data;
    logic                    done_wait;
    dfe_out_t                result;

    int        model_tap  [TAP_COUNT];    // expanded tap values.
    pam4_sym_t model_hist [TAP_COUNT-1];  // [0] is the last decision.
    bit        model_run;
    int        errors;
    int        checks;
    int        seed;

    // taps 16, 8, -4, 2, 0; symbols and equalized values worked out by hand.
    row_t rows [ROWS] = '{
        '{60,   1'b1, sym_p3, 54},
        '{-20,  1'b1, sym_m3, -42},
        '{0,    1'b0, sym_p1, 0},
        '{-10,  1'b1, sym_p1, 24},
        '{-30,  1'b1, sym_m3, -56},
        '{-40,  1'b1, sym_m1, -6},
        '{5,    1'b1, sym_m1, -1},
        '{127,  1'b1, sym_p3, 137},
        '{-120, 1'b1, sym_m3, -146},
        '{20,   1'b1, sym_p3, 58},
        '{10,   1'b1, sym_m1, -32},
        '{0,    1'b1, sym_p1, 26},
        '{50,   1'b1, sym_p3, 32},
        '{18,   1'b1, sym_p1, 0}
    };

    dfe_top u_dfe_top (
        .clk          (clk),
        .rstn         (rstn),
        .sample       (sample),
        .sample_valid (sample_valid),
        .load_mem     (load_mem),
        .location     (location),
        .mem_data     (mem_data),
        .done_wait    (done_wait),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int level_of(input pam4_sym_t sym);
        case (sym)
            sym_m3:  return -3;
            sym_m1:  return -1;
            sym_p1:  return 1;
            default: return 3;
        endcase
    endfunction

    // slicer regions split at zero and at twice the main cursor.
    function automatic pam4_sym_t decide_symbol(input int eq, input int h0);
        if (eq >= 2 * h0) begin
            return sym_p3;
        end else if (eq >= 0) begin
            return sym_p1;
        end else if (eq >= -2 * h0) begin
            return sym_m1;
        end
        return sym_m3;
    endfunction

    task automatic check_val(input string name, input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // drive one cycle on the falling edge, check the result one edge later.
    task automatic run_cycle(input string name, input int smp, input logic vld,
                             input logic ld, input int loc, input int mant, input int shft);
        bit        take;
        int        isi;
        int        eq;
        pam4_sym_t sym;
        take = vld && model_run && !ld;  // writes win over samples.
        isi  = 0;
        for (int k = 1; k < TAP_COUNT; k++) begin
            isi += model_tap[k] * level_of(model_hist[k-1]);
        end
        eq  = smp - isi;
        sym = decide_symbol(eq, model_tap[0]);
        sample        = SIG_W'(smp);
        sample_valid  = vld;
        load_mem      = ld;
        location      = LOC_W'(loc);
        mem_data.mant  = SIG_W'(mant);
        mem_data.shift = 3'(shft);
        @(negedge clk);
        check_val({name, " done_wait"}, 32'(model_run), 32'(done_wait));
        check_val({name, " valid"}, 32'(take), 32'(result.valid));
        if (take) begin
            check_val({name, " symbol"}, 32'(sym), 32'(result.symbol));
            check_val({name, " equalized"}, eq, 32'($signed(result.equalized)));
            for (int k = TAP_COUNT - 2; k > 0; k--) begin
                model_hist[k] = model_hist[k-1];
            end
            model_hist[0] = sym;
        end
        if (ld && loc < TAP_COUNT) begin
            model_tap[loc] = mant * (2 ** shft);
        end
    endtask

    // bounded wait for done_wait, one edge is already spent in the write cycle.
    task automatic wait_ready(input int max_cycles, output bit ok);
        int n;
        n            = 0;
        sample_valid = 1'b0;
        load_mem     = 1'b0;
        while (!done_wait && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        ok = done_wait;
        if (!ok) begin
            errors++;
            $display("done_wait was still low %0d cycles after the last tap write", n + 1);
        end
    endtask

    initial begin
        string name;
        int    r;
        bit    ready_ok;
        errors       = 0;
        checks       = 0;
        seed         = 32'h98d9;
        model_run    = 1'b0;
        rstn         = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        load_mem     = 1'b0;
        location     = '0;
        mem_data     = '0;
        for (int k = 0; k < TAP_COUNT; k++) begin
            model_tap[k] = 0;
        end
        for (int k = 0; k < TAP_COUNT - 1; k++) begin
            model_hist[k] = sym_p1;
        end
        repeat (8) @(negedge clk);
        rstn = 1'b1;

        check_val("reset done_wait", 0, 32'(done_wait));
        check_val("reset valid", 0, 32'(result.valid));
        run_cycle("prefill", 30, 1'b1, 1'b0, 0, 0, 0);
        run_cycle("prefill", -50, 1'b1, 1'b0, 0, 0, 0);

        run_cycle("fill tap0", 0, 1'b0, 1'b1, 0, 4, 2);
        run_cycle("fill tap1", 0, 1'b0, 1'b1, 1, 1, 3);
        run_cycle("fill tap2", 0, 1'b0, 1'b1, 2, 5, 0);
        run_cycle("fill tap3", 0, 1'b0, 1'b1, 3, 1, 1);
        run_cycle("fill tap2 again", 0, 1'b0, 1'b1, 2, -4, 0);
        run_cycle("fill loc6", 0, 1'b0, 1'b1, 6, 99, 1);
        run_cycle("fill idle", 12, 1'b1, 1'b0, 0, 0, 0);
        run_cycle("fill idle", 0, 1'b0, 1'b0, 0, 0, 0);
        run_cycle("fill tap4", 0, 1'b0, 1'b1, 4, 0, 3);
        wait_ready(READY_EDGES - 1, ready_ok);

        if (ready_ok) begin
            model_run = 1'b1;
            for (int i = 0; i < ROWS; i++) begin
                name = $sformatf("table row %0d", i);
                run_cycle(name, rows[i].smp, rows[i].vld, 1'b0, 0, 0, 0);
                if (rows[i].vld) begin
                    check_val({name, " tabled symbol"}, 32'(rows[i].sym), 32'(result.symbol));
                    check_val({name, " tabled equalized"}, rows[i].eq,
                              32'($signed(result.equalized)));
                end
            end

            // sample during a write is dropped and leaves the history alone.
            run_cycle("drop", 40, 1'b1, 1'b1, 4, 0, 0);
            run_cycle("after drop", -25, 1'b1, 1'b0, 0, 0, 0);
            run_cycle("after drop", 35, 1'b1, 1'b0, 0, 0, 0);

            for (int i = 0; i < RAND_COUNT; i++) begin
                r = $random(seed);
                run_cycle($sformatf("random %0d", i), int'($signed(r[7:0])),
                          r[8] | r[9], r[13:10] == 4'd0, int'(r[16:14]),
                          int'($signed(r[24:17])), int'(r[27:25]));
            end

            for (int i = 0; i < BURST_COUNT; i++) begin
                r = $random(seed);
                run_cycle($sformatf("burst %0d", i), int'($signed(r[7:0])), 1'b1,
                          1'b0, 0, 0, 0);
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // hard limit on the whole run.
    initial begin
        int n;
        n = 0;
        while (n < RUN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        $display("simulation did not finish within %0d cycles", RUN_LIMIT);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== dfe_top.f ====
hdl/dfe_pkg.sv
hdl/dfe_ctrl.sv
hdl/coef_fill_tracker.sv
hdl/coef_bank.sv
hdl/symbol_slicer.sv
hdl/isi_canceller.sv
hdl/dfe_top.sv
verification/dfe_tb.sv

// ==== Makefile ====
# Verilator build and run of the DFE testbench.
VERILATOR ?= verilator
TOP       ?= dfe_tb
FILELIST  ?= dfe_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulation passes only if the pass line shows up in its output.
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
